/* rp_analog.f */
+incdir+hdl
hdl/rp_pkg.sv
hdl/adc_frontend.sv
hdl/sys_bus_decoder.sv
hdl/hk_regs.sv
hdl/ams_regs.sv
hdl/pdm_gen.sv
hdl/rp_analog_top.sv
verif/tb_rp_analog.sv

/* verif/tb_rp_analog.sv */
// analog front end testbench

`default_nettype none

`include "rp_defs.svh"

module tb_rp_analog;

  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_ADC, OP_PDM} op_e;

  // adc and pdm rows carry the channel in addr
  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;   // write data or pdm level word
    logic [31:0] exp;    // read value, led value or ones count
    logic        err;
  } entry_t;

  localparam int TBL_N = 36;

  logic                    adc_clk_01;
  logic                    arst_n;
  logic [3:0][13:0]        adc_dat;
  logic [31:0]             addr;
  logic [31:0]             wdata;
  logic                    wen;
  logic                    ren;
  logic [31:0]             rdata;
  logic                    ack;
  logic                    err;
  logic [7:0]              led;
  logic [3:0]              dac_pwm;

  logic [13:0]             raw [4];  // last words driven on the adc pins
  int                      seed = 86;

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  entry_t tbl [TBL_N] = '{
    '{OP_RD,  32'h0000_0000, 32'h0000_0000, `RP_HK_ID,      1'b0},  // id right after reset
    '{OP_RD,  32'h0000_0030, 32'h0000_0000, 32'h0000_0000, 1'b0},  // led reset value
    '{OP_WR,  32'h0000_0030, 32'h0000_01a5, 32'h0000_00a5, 1'b0},  // upper bits dropped
    '{OP_RD,  32'h0000_0030, 32'h0000_0000, 32'h0000_00a5, 1'b0},
    '{OP_WR,  32'h0040_0020, 32'h1234_5611, 32'h0000_0000, 1'b0},  // pdm levels
    '{OP_WR,  32'h0040_0024, 32'hffff_ff80, 32'h0000_0000, 1'b0},
    '{OP_WR,  32'h0040_0028, 32'h0000_00ff, 32'h0000_0000, 1'b0},
    '{OP_WR,  32'h0040_002c, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_RD,  32'h0040_0020, 32'h0000_0000, 32'h0000_0011, 1'b0},
    '{OP_RD,  32'h0040_0024, 32'h0000_0000, 32'h0000_0080, 1'b0},
    '{OP_RD,  32'h0040_0028, 32'h0000_0000, 32'h0000_00ff, 1'b0},
    '{OP_RD,  32'h0040_002c, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_ADC, 32'd0,         32'h0000_0000, 32'h0000_0000, 1'b0},  // fresh random words each row
    '{OP_ADC, 32'd1,         32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_ADC, 32'd2,         32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_ADC, 32'd3,         32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_ADC, 32'd2,         32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_ADC, 32'd0,         32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_PDM, 32'd0,         32'habcd_0040, 32'd64,        1'b0},  // only low byte is the level
    '{OP_PDM, 32'd1,         32'h0000_0001, 32'd1,         1'b0},
    '{OP_PDM, 32'd2,         32'h0000_00ff, 32'd255,       1'b0},
    '{OP_PDM, 32'd3,         32'h0000_0000, 32'd0,         1'b0},  // silent channel
    '{OP_PDM, 32'd0,         32'h0000_00b3, 32'd179,       1'b0},
    '{OP_RD,  32'h0020_0000, 32'h0000_0000, 32'h0000_0000, 1'b1},  // unused regions
    '{OP_RD,  32'h0030_0004, 32'h0000_0000, 32'h0000_0000, 1'b1},
    '{OP_RD,  32'h0050_0000, 32'h0000_0000, 32'h0000_0000, 1'b1},
    '{OP_RD,  32'h0060_0010, 32'h0000_0000, 32'h0000_0000, 1'b1},
    '{OP_RD,  32'h0070_0000, 32'h0000_0000, 32'h0000_0000, 1'b1},
    '{OP_WR,  32'h0020_0000, 32'hdead_beef, 32'h0000_0000, 1'b1},
    '{OP_WR,  32'h0070_0030, 32'h0000_005a, 32'h0000_0000, 1'b1},
    '{OP_RD,  32'h0000_0044, 32'h0000_0000, 32'h0000_0000, 1'b0},  // hole in region 0
    '{OP_WR,  32'h0000_0044, 32'h0000_00ff, 32'h0000_0000, 1'b0},  // dropped silently
    '{OP_RD,  32'h0000_0030, 32'h0000_0000, 32'h0000_00a5, 1'b0},  // led untouched
    '{OP_RD,  32'hff80_0000, 32'h0000_0000, `RP_HK_ID,      1'b0},  // high bits ignored
    '{OP_RD,  32'h0010_0010, 32'h0000_0000, 32'h0000_0000, 1'b0},  // adc hole reads zero
    '{OP_WR,  32'h0010_0000, 32'h0000_1234, 32'h0000_0000, 1'b1}   // adc region is read only
  };

  rp_analog_top i_dut (
    .adc_clk_01 (adc_clk_01), .arst_n_i (arst_n),  .adc_dat_i (adc_dat),
    .addr_i     (addr),       .wdata_i  (wdata),   .wen_i     (wen),    .ren_i (ren),
    .rdata_o    (rdata),      .ack_o    (ack),     .err_o     (err),
    .led_o      (led),        .dac_pwm_o(dac_pwm)
  );

  initial begin
    adc_clk_01 = 1'b0;
    forever #4 adc_clk_01 = ~adc_clk_01;  // 125 MHz
  end

  // longest row is a pdm count of 256 cycles
  initial begin
    repeat (TBL_N * 300) @(posedge adc_clk_01);
    $display("timeout: the test sequence did not finish in time");
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "first mismatch, run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  // low 13 bits flipped by the mask and the result sign extended
  function automatic logic [31:0] convert_raw(input logic [13:0] raw_w);
    logic [13:0] smp;
    smp = raw_w ^ 14'h1fff;
    return {{18{smp[13]}}, smp};
  endfunction

  // one strobe with the ack due one cycle later for exactly one cycle
  task automatic bus_access(input logic wr, input logic [31:0] a, input logic [31:0] d,
                            output logic [31:0] rd, output logic er);
    @(posedge adc_clk_01);
    addr  <= a;
    wdata <= d;
    wen   <= wr;
    ren   <= ~wr;
    @(posedge adc_clk_01);
    wen <= 1'b0;
    ren <= 1'b0;
    @(negedge adc_clk_01);
    check_value("ack_o", ack, 1);
    rd = rdata;
    er = err;
    @(negedge adc_clk_01);
    check_value("ack_o", ack, 0);                           // single cycle ack
  endtask

  // new words on all channels held long enough for both stages
  task automatic drive_adc_words();
    logic [31:0] rnd;
    @(posedge adc_clk_01);
    for (int k = 0; k < 4; k++) begin
      rnd    = $random(seed);
      raw[k] = rnd[13:0];
      adc_dat[k] <= rnd[13:0];
    end
    repeat (3) @(posedge adc_clk_01);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic        er;
    int          ones;
    int          ch;
    arst_n  = 1'b0;
    adc_dat = '0;
    addr    = '0;
    wdata   = '0;
    wen     = 1'b0;
    ren     = 1'b0;
    repeat (4) @(posedge adc_clk_01);
    arst_n <= 1'b1;
    @(negedge adc_clk_01);
    check_value("led_o", led, 0);
    check_value("dac_pwm_o", dac_pwm, 0);
    check_value("ack_o", ack, 0);
    check_value("err_o", err, 0);

    for (int i = 0; i < TBL_N; i++) begin
      ch = tbl[i].addr;
      case (tbl[i].op)
        OP_WR: begin
          bus_access(1'b1, tbl[i].addr, tbl[i].data, rd, er);
          check_value("err_o", er, tbl[i].err);
          if (tbl[i].err)
            check_value("rdata_o", rd, 0);                 // error answers read zero
          if (tbl[i].addr == 32'h0000_0030)
            check_value("led_o", led, tbl[i].exp[7:0]);
        end
        OP_RD: begin
          bus_access(1'b0, tbl[i].addr, 32'h0, rd, er);
          check_value("err_o", er, tbl[i].err);
          check_value("rdata_o", rd, tbl[i].exp);
        end
        OP_ADC: begin
          drive_adc_words();
          bus_access(1'b0, 32'h0010_0000 | (ch << 2), 32'h0, rd, er);
          check_value("err_o", er, 0);
          check_value("rdata_o", rd, convert_raw(raw[ch]));
        end
        default: begin
          // level write followed by one full pdm period
          bus_access(1'b1, 32'h0040_0020 + (ch << 2), tbl[i].data, rd, er);
          check_value("err_o", er, 0);
          ones = 0;
          repeat (256) begin
            @(negedge adc_clk_01);
            ones += dac_pwm[ch];
          end
          check_value("dac_pwm_o ones", ones, tbl[i].exp);
        end
      endcase
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule : tb_rp_analog

`default_nettype wire

/* hdl/rp_analog_top.sv */
// analog front end top

`default_nettype none

`include "rp_defs.svh"

module rp_analog_top (
  input  wire logic                                     adc_clk_01,
  input  wire logic                                     arst_n_i,
  input  wire logic [`RP_ADC_CH-1:0][`RP_ADC_DW-1:0]    adc_dat_i,  // raw adc words
  // system bus
  input  wire logic [`RP_BUS_AW-1:0]                    addr_i,
  input  wire logic [`RP_BUS_DW-1:0]                    wdata_i,
  input  wire logic                                     wen_i,
  input  wire logic                                     ren_i,
  output logic      [`RP_BUS_DW-1:0]                    rdata_o,
  output logic                                          ack_o,
  output logic                                          err_o,
  // board outputs
  output logic      [`RP_PDM_DW-1:0]                    led_o,
  output logic      [`RP_PDM_CH-1:0]                    dac_pwm_o   // pdm dacs
);

  logic                                  hk_wen, hk_ren, hk_ack;
  logic                                  adc_ren, adc_ack;
  logic                                  ams_wen, ams_ren, ams_ack;
  logic [`RP_BUS_DW-1:0]                 hk_rdata, adc_rdata, ams_rdata;
  logic [`RP_PDM_CH-1:0][`RP_PDM_DW-1:0] pdm_lvl;

  //////////////////////////////////////////////////////////////////////
  // bus split into 8 regions
  //////////////////////////////////////////////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk_01 (adc_clk_01), .arst_n_i   (arst_n_i),
    .addr_i     (addr_i),     .wen_i      (wen_i),      .ren_i    (ren_i),
    .rdata_o    (rdata_o),    .ack_o      (ack_o),      .err_o    (err_o),
    .hk_wen_o   (hk_wen),     .hk_ren_o   (hk_ren),
    .hk_rdata_i (hk_rdata),   .hk_ack_i   (hk_ack),     .hk_err_i (1'b0),  // never errs
    .adc_ren_o  (adc_ren),
    .adc_rdata_i(adc_rdata),  .adc_ack_i  (adc_ack),    .adc_err_i(1'b0),
    .ams_wen_o  (ams_wen),    .ams_ren_o  (ams_ren),
    .ams_rdata_i(ams_rdata),  .ams_ack_i  (ams_ack),    .ams_err_i(1'b0)
  );

  // region 1
  adc_frontend i_adc (
    .adc_clk_01 (adc_clk_01), .arst_n_i (arst_n_i), .adc_dat_i (adc_dat_i),
    .addr_i     (addr_i),     .ren_i    (adc_ren),
    .rdata_o    (adc_rdata),  .ack_o    (adc_ack)
  );

  // region 0
  hk_regs i_hk (
    .adc_clk_01 (adc_clk_01), .arst_n_i (arst_n_i),
    .addr_i     (addr_i),     .wdata_i  (wdata_i),  .wen_i (hk_wen), .ren_i (hk_ren),
    .rdata_o    (hk_rdata),   .ack_o    (hk_ack),   .led_o (led_o)
  );

  //////////////////////////////////////////////////////////////////////
  // pdm outputs, levels set in region 4
  //////////////////////////////////////////////////////////////////////

  ams_regs i_ams (
    .adc_clk_01 (adc_clk_01), .arst_n_i (arst_n_i),
    .addr_i     (addr_i),     .wdata_i  (wdata_i),  .wen_i (ams_wen), .ren_i (ams_ren),
    .rdata_o    (ams_rdata),  .ack_o    (ams_ack),  .pdm_lvl_o (pdm_lvl)
  );

  pdm_gen i_pdm (
    .adc_clk_01 (adc_clk_01), .arst_n_i (arst_n_i),
    .pdm_lvl_i  (pdm_lvl),    .pdm_o    (dac_pwm_o)
  );

endmodule : rp_analog_top

`default_nettype wire

/* hdl/pdm_gen.sv */
// first order pdm modulators

`default_nettype none

`include "rp_defs.svh"

module pdm_gen (
  input  wire logic                                     adc_clk_01,
  input  wire logic                                     arst_n_i,
  input  wire logic [`RP_PDM_CH-1:0][`RP_PDM_DW-1:0]    pdm_lvl_i,
  output logic      [`RP_PDM_CH-1:0]                    pdm_o
);

  //////////////////////////////////////////////////////////////////////
  // one accumulator per channel with range fixed at 256 steps
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < `RP_PDM_CH; k++) begin : g_ch
    logic [`RP_PDM_DW-1:0] acc;   // phase
    logic [`RP_PDM_DW:0]   sum;   // carry on top

    assign sum = {1'b0, acc} + {1'b0, pdm_lvl_i[k]};

    always_ff @(posedge adc_clk_01 or negedge arst_n_i) begin
      if (!arst_n_i) begin
        acc      <= '0;
        pdm_o[k] <= 1'b0;
      end else begin
        acc      <= sum[`RP_PDM_DW-1:0];  // wraps every 256
        pdm_o[k] <= sum[`RP_PDM_DW];      // duty = level/256
      end
    end
  end : g_ch

endmodule : pdm_gen

`default_nettype wire

/* hdl/ams_regs.sv */
// pdm level registers

`default_nettype none

`include "rp_defs.svh"

module ams_regs import rp_pkg::*; (
  input  wire logic                                     adc_clk_01,
  input  wire logic                                     arst_n_i,
  input  wire logic [`RP_BUS_AW-1:0]                    addr_i,
  input  wire logic [`RP_BUS_DW-1:0]                    wdata_i,
  input  wire logic                                     wen_i,
  input  wire logic                                     ren_i,
  output logic      [`RP_BUS_DW-1:0]                    rdata_o,
  output logic                                          ack_o,
  output logic      [`RP_PDM_CH-1:0][`RP_PDM_DW-1:0]    pdm_lvl_o
);

  localparam logic [`RP_REG_SW-1:0] OFS_DAC = `RP_AMS_OFS_DAC;

  sys_addr_u addr_u;

  assign addr_u.flat = addr_i;

  //////////////////////////////////////////////////////////////////////
  // level registers at 0x20, 0x24, 0x28, 0x2c
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pdm_lvl_o <= '0;
      ack_o     <= 1'b0;
      rdata_o   <= '0;
    end else begin
      ack_o <= wen_i | ren_i;
      if (ren_i)
        rdata_o <= '0;  // unless one of the levels matches
      for (int k = 0; k < `RP_PDM_CH; k++) begin
        if (addr_u.f.ofs == OFS_DAC + `RP_REG_SW'(4 * k)) begin
          if (wen_i)
            pdm_lvl_o[k] <= wdata_i[`RP_PDM_DW-1:0];  // low byte only
          if (ren_i)
            rdata_o <= {{(`RP_BUS_DW-`RP_PDM_DW){1'b0}}, pdm_lvl_o[k]};
        end
      end
    end
  end

endmodule : ams_regs

`default_nettype wire

/* hdl/hk_regs.sv */
// housekeeping registers

`default_nettype none

`include "rp_defs.svh"

module hk_regs import rp_pkg::*; (
  input  wire logic                  adc_clk_01,
  input  wire logic                  arst_n_i,
  input  wire logic [`RP_BUS_AW-1:0] addr_i,
  input  wire logic [`RP_BUS_DW-1:0] wdata_i,
  input  wire logic                  wen_i,
  input  wire logic                  ren_i,
  output logic      [`RP_BUS_DW-1:0] rdata_o,
  output logic                       ack_o,
  output logic      [`RP_PDM_DW-1:0] led_o
);

  sys_addr_u addr_u;

  assign addr_u.flat = addr_i;

  // led register, written straight to the pins
  always_ff @(posedge adc_clk_01 or negedge arst_n_i) begin
    if (!arst_n_i)
      led_o <= '0;
    else if (wen_i && (addr_u.f.ofs == `RP_HK_OFS_LED))
      led_o <= wdata_i[`RP_PDM_DW-1:0];  // upper bits dropped
  end

  //////////////////////////////////////////////////////////////////////
  // read side and ack
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      ack_o <= wen_i | ren_i;  // writes ack too
      if (ren_i) begin
        case (addr_u.f.ofs)
          `RP_HK_OFS_ID:  rdata_o <= `RP_HK_ID;  // read only
          `RP_HK_OFS_LED: rdata_o <= {{(`RP_BUS_DW-`RP_PDM_DW){1'b0}}, led_o};
          default:        rdata_o <= '0;
        endcase
      end
    end
  end

  // master never issues both strobes at once
  a_strobe_excl : assert property (@(posedge adc_clk_01) disable iff (!arst_n_i)
    !(wen_i && ren_i));

endmodule : hk_regs

`default_nettype wire

/* hdl/sys_bus_decoder.sv */
// system bus region decoder

`default_nettype none

`include "rp_defs.svh"

module sys_bus_decoder import rp_pkg::*; (
  input  wire logic                  adc_clk_01,
  input  wire logic                  arst_n_i,
  // master side
  input  wire logic [`RP_BUS_AW-1:0] addr_i,
  input  wire logic                  wen_i,
  input  wire logic                  ren_i,
  output logic      [`RP_BUS_DW-1:0] rdata_o,
  output logic                       ack_o,
  output logic                       err_o,
  // region 0, housekeeping
  output logic                       hk_wen_o,
  output logic                       hk_ren_o,
  input  wire logic [`RP_BUS_DW-1:0] hk_rdata_i,
  input  wire logic                  hk_ack_i,
  input  wire logic                  hk_err_i,
  // region 1, adc readback (read only)
  output logic                       adc_ren_o,
  input  wire logic [`RP_BUS_DW-1:0] adc_rdata_i,
  input  wire logic                  adc_ack_i,
  input  wire logic                  adc_err_i,
  // region 4, ams levels
  output logic                       ams_wen_o,
  output logic                       ams_ren_o,
  input  wire logic [`RP_BUS_DW-1:0] ams_rdata_i,
  input  wire logic                  ams_ack_i,
  input  wire logic                  ams_err_i
);

  sys_addr_u addr_u;
  logic      sel_hk, sel_adc, sel_ams;
  logic      own_sel;   // access answered here
  logic      own_ack_q; // own response, always with err

  assign addr_u.flat = addr_i;

  //////////////////////////////////////////////////////////////////////
  // region select and strobe gating
  //////////////////////////////////////////////////////////////////////

  assign sel_hk  = (addr_u.f.region == `RP_REGION_HK);
  assign sel_adc = (addr_u.f.region == `RP_REGION_ADC);
  assign sel_ams = (addr_u.f.region == `RP_REGION_AMS);

  assign hk_wen_o  = wen_i & sel_hk;
  assign hk_ren_o  = ren_i & sel_hk;
  assign adc_ren_o = ren_i & sel_adc;
  assign ams_wen_o = wen_i & sel_ams;
  assign ams_ren_o = ren_i & sel_ams;

  // regions 2,3,5,6,7 plus a write into the read-only adc region
  assign own_sel = ((wen_i | ren_i) & ~(sel_hk | sel_adc | sel_ams))
                 | (wen_i & sel_adc);

  always_ff @(posedge adc_clk_01 or negedge arst_n_i) begin
    if (!arst_n_i)
      own_ack_q <= 1'b0;
    else
      own_ack_q <= own_sel;  // same latency as a slave
  end

  //////////////////////////////////////////////////////////////////////
  // response mux
  //////////////////////////////////////////////////////////////////////

  // acks are one-hot, so and-or is enough; own response reads zero
  assign rdata_o = ({`RP_BUS_DW{hk_ack_i}}  & hk_rdata_i)
                 | ({`RP_BUS_DW{adc_ack_i}} & adc_rdata_i)
                 | ({`RP_BUS_DW{ams_ack_i}} & ams_rdata_i);

  assign ack_o = hk_ack_i | adc_ack_i | ams_ack_i | own_ack_q;

  assign err_o = own_ack_q
               | (hk_ack_i  & hk_err_i)
               | (adc_ack_i & adc_err_i)
               | (ams_ack_i & ams_err_i);

  // strobes are gated to one region, so one responder per cycle
  a_ack_onehot : assert property (@(posedge adc_clk_01) disable iff (!arst_n_i)
    $onehot0({hk_ack_i, adc_ack_i, ams_ack_i, own_ack_q}));

endmodule : sys_bus_decoder

`default_nettype wire

/* hdl/adc_frontend.sv */
// adc conversion and readback

`default_nettype none

`include "rp_defs.svh"

module adc_frontend import rp_pkg::*; (
  input  wire logic                                     adc_clk_01,
  input  wire logic                                     arst_n_i,
  input  wire logic [`RP_ADC_CH-1:0][`RP_ADC_DW-1:0]    adc_dat_i,  // raw, inverted offset
  input  wire logic [`RP_BUS_AW-1:0]                    addr_i,
  input  wire logic                                     ren_i,      // already region gated
  output logic      [`RP_BUS_DW-1:0]                    rdata_o,
  output logic                                          ack_o
);

  logic [`RP_ADC_CH-1:0][`RP_ADC_DW-1:0] adc_dat_r;  // stage 1
  adc_smp_t [`RP_ADC_CH-1:0]             adc_smp;    // stage 2, readable
  sys_addr_u                             addr_u;
  logic                                  ofs_hit;
  logic [1:0]                            ch;

  //////////////////////////////////////////////////////////////////////
  // conversion pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      adc_dat_r <= '0;
      adc_smp   <= '0;
    end else begin
      for (int k = 0; k < `RP_ADC_CH; k++) begin
        // msb stays, the rest flips
        adc_dat_r[k] <= {adc_dat_i[k][`RP_ADC_DW-1], ~adc_dat_i[k][`RP_ADC_DW-2:0]};
        adc_smp[k]   <= adc_dat_r[k];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus readback
  //////////////////////////////////////////////////////////////////////

  assign addr_u.flat = addr_i;
  assign ch          = addr_u.f.ofs[3:2];                    // 0x0, 0x4, 0x8, 0xc
  assign ofs_hit     = (addr_u.f.ofs[`RP_REG_SW-1:4] == '0)
                    && (addr_u.f.ofs[1:0] == 2'b00);

  always_ff @(posedge adc_clk_01 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      ack_o <= ren_i;                                        // no wait states
      if (ren_i) begin
        rdata_o <= '0;                                       // unknown offset
        if (ofs_hit)
          rdata_o <= {{(`RP_BUS_DW-`RP_ADC_DW){adc_smp[ch][`RP_ADC_DW-1]}}, adc_smp[ch]};
      end
    end
  end

  // one read per ack, the master waits for it
  a_ack_single : assert property (@(posedge adc_clk_01) disable iff (!arst_n_i)
    ack_o |=> !ack_o);

endmodule : adc_frontend

`default_nettype wire

/* hdl/rp_pkg.sv */
// front end shared types

`default_nettype none

`include "rp_defs.svh"

package rp_pkg;

  // bus address, seen flat or split into fields
  typedef union packed {
    logic [`RP_BUS_AW-1:0] flat;   // as driven on the bus
    struct packed {
      logic [`RP_BUS_AW-`RP_REGION_W-`RP_REG_SW-1:0] hi;  // don't care
      logic [`RP_REGION_W-1:0]                       region;  // decoder view
      logic [`RP_REG_SW-1:0]                         ofs;     // slave view
    } f;
  } sys_addr_u;

  // converted adc sample, two's complement
  typedef logic signed [`RP_ADC_DW-1:0] adc_smp_t;

endpackage : rp_pkg

`default_nettype wire

/* hdl/rp_defs.svh */
// analog front end parameters

`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

// adc stream
`define RP_ADC_DW      14            // raw and converted sample width
`define RP_ADC_CH      4             // adc channels

// system bus
`define RP_BUS_AW      32
`define RP_BUS_DW      32
`define RP_REG_SW      20            // offset bits inside one region
`define RP_REGION_W    3             // addr[22:20]

// region map
`define RP_REGION_HK   3'd0
`define RP_REGION_ADC  3'd1          // adc readback
`define RP_REGION_AMS  3'd4

// housekeeping
`define RP_HK_ID       32'h5250_0a01 // board id word
`define RP_HK_OFS_ID   20'h00000
`define RP_HK_OFS_LED  20'h00030

// ams levels and pdm
`define RP_AMS_OFS_DAC 20'h00020     // level 0, next ones every 4 bytes
`define RP_PDM_DW      8             // also the led register width
`define RP_PDM_CH      4

`endif
